// File: Makefile
TOP := tb_priv_csr

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: sources.f
+incdir+src
src/priv_pkg.sv
src/csr_decode.sv
src/csr_rfile.sv
src/trap_unit.sv
src/priv_csr_top.sv
verif/priv_csr_assertions.sv
verif/tb_priv_csr.sv

// File: src/csr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "priv_macros.svh"

module csr_decode import priv_pkg::*; (
  input  logic        instr_valid,
  input  word_t       instr,
  input  word_t       rs1_data,
  output csr_op_e     csr_op,
  output logic [11:0] csr_addr,
  output word_t       csr_wdata,
  output logic        csr_write_en,
  output logic        is_ecall,
  output logic        is_ebreak,
  output logic        is_mret,
  output logic        decode_illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rs1_idx;
  logic [4:0] rd_idx;
  logic       system;

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign rs1_idx = instr[19:15];
  assign rd_idx  = instr[11:7];
  assign system  = instr_valid && (opcode == `OPC_SYSTEM);

  // funct12 doubles as the CSR address
  assign csr_addr = instr[31:20];

  // Immediate forms carry a 5-bit zero-extended value in the rs1 field
  assign csr_wdata = funct3[2] ? {27'b0, rs1_idx} : rs1_data;

  always_comb begin
    csr_op         = NONE;
    csr_write_en   = 1'b0;
    is_ecall       = 1'b0;
    is_ebreak      = 1'b0;
    is_mret        = 1'b0;
    decode_illegal = 1'b0;
    if (system) begin
      case (funct3[1:0])
        2'b01: begin
          csr_op       = SWAP;
          csr_write_en = 1'b1;
        end
        // Set and clear with x0 or zero immediate only read
        2'b10: begin
          csr_op       = SET;
          csr_write_en = (rs1_idx != 5'd0);
        end
        2'b11: begin
          csr_op       = CLR;
          csr_write_en = (rs1_idx != 5'd0);
        end
        default: begin
          if (funct3[2] || (rs1_idx != 5'd0) || (rd_idx != 5'd0)) begin
            decode_illegal = 1'b1;
          end else begin
            case (csr_addr)
              `FUNCT12_ECALL:  is_ecall  = 1'b1;
              `FUNCT12_EBREAK: is_ebreak = 1'b1;
              `FUNCT12_MRET:   is_mret   = 1'b1;
              default:         decode_illegal = 1'b1;
            endcase
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/csr_rfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "priv_macros.svh"

module csr_rfile import priv_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  csr_op_e     csr_op,
  input  logic [11:0] csr_addr,
  input  word_t       csr_wdata,
  input  logic        csr_write_en,
  input  logic        instr_retired,
  input  logic        ext_irq,
  input  logic        trap_take,
  input  logic        mret_take,
  input  mcause_u     cause,
  input  word_t       trap_pc,
  input  word_t       trap_value,
  output word_t       rdata,
  output logic        addr_invalid,
  output mstatus_t    mstatus,
  output word_t       mie,
  output word_t       mtvec,
  output word_t       mepc,
  output logic        timer_pending,
  output logic        ext_pending
);

  logic        st_mie;
  logic        st_mpie;
  word_t       mscratch;
  mcause_u     mcause;
  word_t       mtval;
  word_t       mtimecmp;
  word_t       mip;
  logic [63:0] cycle_cnt;
  logic [63:0] instret_cnt;
  logic [63:0] time_cnt;
  logic        known;
  logic        wr_en;
  word_t       wval;

  // Only the timer and external enables exist
  localparam word_t MIE_MASK = (32'd1 << `MIE_MTIE_BIT) | (32'd1 << `MIE_MEIE_BIT);

  // Increment, then let a CSR write replace either half
  function automatic logic [63:0] count_next(input logic [63:0] cnt, input logic inc,
                                             input logic wr_lo, input logic wr_hi,
                                             input word_t val);
    logic [63:0] nxt;
    nxt = cnt + {63'b0, inc};
    if (wr_lo) begin
      nxt[31:0] = val;
    end
    if (wr_hi) begin
      nxt[63:32] = val;
    end
    return nxt;
  endfunction

  always_comb begin
    mstatus      = '0;
    mstatus.mpp  = 2'b11;
    mstatus.mie  = st_mie;
    mstatus.mpie = st_mpie;
  end

  assign ext_pending   = ext_irq;
  assign timer_pending = (mtimecmp != '0) && (time_cnt >= {32'b0, mtimecmp});

  always_comb begin
    mip = '0;
    mip[`MIE_MTIE_BIT] = timer_pending;
    mip[`MIE_MEIE_BIT] = ext_pending;
  end

  // Read mux, identity registers read zero
  always_comb begin
    known = 1'b1;
    rdata = '0;
    case (csr_addr)
      `CSR_MSTATUS:   rdata = mstatus;
      `CSR_MISA:      rdata = `MISA_VALUE;
      `CSR_MIE:       rdata = mie;
      `CSR_MTVEC:     rdata = mtvec;
      `CSR_MSCRATCH:  rdata = mscratch;
      `CSR_MEPC:      rdata = mepc;
      `CSR_MCAUSE:    rdata = mcause.raw;
      `CSR_MTVAL:     rdata = mtval;
      `CSR_MIP:       rdata = mip;
      `CSR_MTIMECMP:  rdata = mtimecmp;
      `CSR_MTIME:     rdata = time_cnt[31:0];
      `CSR_MTIMEH:    rdata = time_cnt[63:32];
      `CSR_MCYCLE:    rdata = cycle_cnt[31:0];
      `CSR_MCYCLEH:   rdata = cycle_cnt[63:32];
      `CSR_MINSTRET:  rdata = instret_cnt[31:0];
      `CSR_MINSTRETH: rdata = instret_cnt[63:32];
      `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID: rdata = '0;
      default:        known = 1'b0;
    endcase
  end

  // Top two address bits set mark a read-only register
  assign addr_invalid = (csr_op != NONE) &&
                        (!known || (csr_write_en && (csr_addr[11:10] == 2'b11)));
  assign wr_en = (csr_op != NONE) && csr_write_en && !addr_invalid && !trap_take;

  always_comb begin
    case (csr_op)
      SWAP:    wval = csr_wdata;
      SET:     wval = rdata | csr_wdata;
      CLR:     wval = rdata & ~csr_wdata;
      default: wval = rdata;
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      st_mie      <= 1'b0;
      st_mpie     <= 1'b0;
      mie         <= '0;
      mtvec       <= '0;
      mtimecmp    <= '0;
      cycle_cnt   <= '0;
      instret_cnt <= '0;
      time_cnt    <= '0;
    end else begin
      cycle_cnt   <= count_next(cycle_cnt, 1'b1, wr_en && (csr_addr == `CSR_MCYCLE),
                                wr_en && (csr_addr == `CSR_MCYCLEH), wval);
      instret_cnt <= count_next(instret_cnt, instr_retired,
                                wr_en && (csr_addr == `CSR_MINSTRET),
                                wr_en && (csr_addr == `CSR_MINSTRETH), wval);
      time_cnt    <= count_next(time_cnt, 1'b1, wr_en && (csr_addr == `CSR_MTIME),
                                wr_en && (csr_addr == `CSR_MTIMEH), wval);
      // Interrupt enable stack
      if (trap_take) begin
        st_mpie <= st_mie;
        st_mie  <= 1'b0;
      end else if (mret_take) begin
        st_mie  <= st_mpie;
        st_mpie <= 1'b1;
      end else if (wr_en && (csr_addr == `CSR_MSTATUS)) begin
        st_mie  <= wval[3];
        st_mpie <= wval[7];
      end
      if (wr_en) begin
        case (csr_addr)
          `CSR_MIE:      mie      <= wval & MIE_MASK;
          `CSR_MTVEC:    mtvec    <= wval;
          `CSR_MTIMECMP: mtimecmp <= wval;
          default:       ;
        endcase
      end
    end
  end

  // Trap CSRs and scratch
  always_ff @(posedge CLK) begin
    if (trap_take) begin
      mepc   <= trap_pc;
      mcause <= cause;
      mtval  <= trap_value;
    end else if (wr_en) begin
      case (csr_addr)
        `CSR_MSCRATCH: mscratch   <= wval;
        `CSR_MEPC:     mepc       <= wval;
        `CSR_MCAUSE:   mcause.raw <= wval;
        `CSR_MTVAL:    mtval      <= wval;
        default:       ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/priv_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module priv_csr_top import priv_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  instr_valid,
  input  word_t instr,
  input  word_t pc,
  input  word_t rs1_data,
  input  logic  instr_retired,
  input  logic  ext_irq,
  output word_t rd_data,
  output logic  rd_write,
  output logic  redirect,
  output word_t redirect_pc,
  output logic  timer_irq
);

  csr_op_e     csr_op;
  logic [11:0] csr_addr;
  word_t       csr_wdata;
  logic        csr_write_en;
  logic        is_ecall;
  logic        is_ebreak;
  logic        is_mret;
  logic        decode_illegal;
  logic        addr_invalid;
  mstatus_t    mstatus;
  word_t       mie;
  word_t       mtvec;
  word_t       mepc;
  logic        ext_pending;
  logic        trap_take;
  logic        mret_take;
  mcause_u     cause;
  word_t       trap_value;

  csr_decode u_decode (
    .instr_valid    (instr_valid),
    .instr          (instr),
    .rs1_data       (rs1_data),
    .csr_op         (csr_op),
    .csr_addr       (csr_addr),
    .csr_wdata      (csr_wdata),
    .csr_write_en   (csr_write_en),
    .is_ecall       (is_ecall),
    .is_ebreak      (is_ebreak),
    .is_mret        (is_mret),
    .decode_illegal (decode_illegal)
  );

  // The trapping instruction's pc goes to mepc
  csr_rfile u_rfile (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_op        (csr_op),
    .csr_addr      (csr_addr),
    .csr_wdata     (csr_wdata),
    .csr_write_en  (csr_write_en),
    .instr_retired (instr_retired),
    .ext_irq       (ext_irq),
    .trap_take     (trap_take),
    .mret_take     (mret_take),
    .cause         (cause),
    .trap_pc       (pc),
    .trap_value    (trap_value),
    .rdata         (rd_data),
    .addr_invalid  (addr_invalid),
    .mstatus       (mstatus),
    .mie           (mie),
    .mtvec         (mtvec),
    .mepc          (mepc),
    .timer_pending (timer_irq),
    .ext_pending   (ext_pending)
  );

  trap_unit u_trap (
    .instr_valid    (instr_valid),
    .pc             (pc),
    .instr          (instr),
    .is_ecall       (is_ecall),
    .is_ebreak      (is_ebreak),
    .is_mret        (is_mret),
    .decode_illegal (decode_illegal),
    .addr_invalid   (addr_invalid),
    .mstatus        (mstatus),
    .mie            (mie),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .timer_pending  (timer_irq),
    .ext_pending    (ext_pending),
    .trap_take      (trap_take),
    .mret_take      (mret_take),
    .cause          (cause),
    .trap_value     (trap_value),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .rd_write       (rd_write)
  );

endmodule

`default_nettype wire

// File: src/priv_macros.svh
`ifndef PRIV_MACROS_SVH
`define PRIV_MACROS_SVH

// Machine trap setup and handling
`define CSR_MSTATUS    12'h300
`define CSR_MISA       12'h301
`define CSR_MIE        12'h304
`define CSR_MTVEC      12'h305
`define CSR_MSCRATCH   12'h340
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MTVAL      12'h343
`define CSR_MIP        12'h344

// Timer block, placed in the custom read/write space
`define CSR_MTIMECMP   12'h7c0
`define CSR_MTIME      12'h7c1
`define CSR_MTIMEH     12'h7c2

// Machine counters
`define CSR_MCYCLE     12'hb00
`define CSR_MINSTRET   12'hb02
`define CSR_MCYCLEH    12'hb80
`define CSR_MINSTRETH  12'hb82

// Identity registers
`define CSR_MVENDORID  12'hf11
`define CSR_MARCHID    12'hf12
`define CSR_MIMPID     12'hf13
`define CSR_MHARTID    12'hf14

// RV32I base, no extensions
`define MISA_VALUE     32'h40000100

`define MIE_MTIE_BIT   7
`define MIE_MEIE_BIT   11

// Exception and interrupt codes
`define CAUSE_ILLEGAL      31'd2
`define CAUSE_BREAKPOINT   31'd3
`define CAUSE_ECALL_M      31'd11
`define CAUSE_M_TIMER_INT  31'd7
`define CAUSE_M_EXT_INT    31'd11

// SYSTEM instruction encodings
`define OPC_SYSTEM     7'b1110011
`define FUNCT12_ECALL  12'h000
`define FUNCT12_EBREAK 12'h001
`define FUNCT12_MRET   12'h302

`endif

// File: src/priv_pkg.sv
`default_nettype none

package priv_pkg;

  typedef logic [31:0] word_t;

  // CSR access kind, NONE for anything that is not a Zicsr instruction
  typedef enum logic [1:0] {
    NONE = 2'b00,
    SWAP = 2'b01,
    SET  = 2'b10,
    CLR  = 2'b11
  } csr_op_e;

  // Cause word as the trap unit builds it
  typedef struct packed {
    logic        irq;
    logic [30:0] code;
  } mcause_fields_t;

  // Same 32 bits seen as fields or as the stored word
  typedef union packed {
    mcause_fields_t f;
    word_t          raw;
  } mcause_u;

  // Machine status, only the interrupt enable stack is live
  typedef struct packed {
    logic [18:0] rsvd_hi;
    logic [1:0]  mpp;
    logic [2:0]  rsvd_b;
    logic        mpie;
    logic [2:0]  rsvd_a;
    logic        mie;
    logic [2:0]  rsvd_lo;
  } mstatus_t;

endpackage

`default_nettype wire

// File: src/trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "priv_macros.svh"

module trap_unit import priv_pkg::*; (
  input  logic     instr_valid,
  input  word_t    pc,
  input  word_t    instr,
  input  logic     is_ecall,
  input  logic     is_ebreak,
  input  logic     is_mret,
  input  logic     decode_illegal,
  input  logic     addr_invalid,
  input  mstatus_t mstatus,
  input  word_t    mie,
  input  word_t    mtvec,
  input  word_t    mepc,
  input  logic     timer_pending,
  input  logic     ext_pending,
  output logic     trap_take,
  output logic     mret_take,
  output mcause_u  cause,
  output word_t    trap_value,
  output logic     redirect,
  output word_t    redirect_pc,
  output logic     rd_write
);

  logic irq_ext;
  logic irq_tmr;
  logic illegal;
  logic is_csr;

  // Interrupts are taken in place of a valid instruction
  assign irq_ext = instr_valid && mstatus.mie && mie[`MIE_MEIE_BIT] && ext_pending;
  assign irq_tmr = instr_valid && mstatus.mie && mie[`MIE_MTIE_BIT] && timer_pending;
  assign illegal = decode_illegal || addr_invalid;

  // Fixed priority, highest first
  always_comb begin
    trap_take = 1'b1;
    cause     = '0;
    if (irq_ext) begin
      cause.f.irq  = 1'b1;
      cause.f.code = `CAUSE_M_EXT_INT;
    end else if (irq_tmr) begin
      cause.f.irq  = 1'b1;
      cause.f.code = `CAUSE_M_TIMER_INT;
    end else if (illegal) begin
      cause.f.code = `CAUSE_ILLEGAL;
    end else if (is_ebreak) begin
      cause.f.code = `CAUSE_BREAKPOINT;
    end else if (is_ecall) begin
      cause.f.code = `CAUSE_ECALL_M;
    end else begin
      trap_take = 1'b0;
    end
  end

  assign trap_value = (illegal && !irq_ext && !irq_tmr) ? instr : '0;
  assign mret_take  = is_mret && !trap_take;
  assign redirect   = trap_take || mret_take;

  // Fall-through address when nothing redirects
  always_comb begin
    if (trap_take) begin
      redirect_pc = {mtvec[31:2], 2'b00};
    end else if (mret_take) begin
      redirect_pc = mepc;
    end else begin
      redirect_pc = pc + 32'd4;
    end
  end

  // funct3 of 000 and 100 never write rd
  assign is_csr   = instr_valid && (instr[6:0] == `OPC_SYSTEM) && (instr[13:12] != 2'b00);
  assign rd_write = is_csr && !trap_take;

endmodule

`default_nettype wire

// File: verif/priv_csr_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module priv_csr_assertions import priv_pkg::*; (
  input logic     CLK,
  input logic     nRST,
  input logic     rd_write,
  input logic     redirect,
  input logic     timer_irq,
  input logic     trap_take,
  input word_t    pc,
  input word_t    mepc,
  input mstatus_t mstatus
);

  // A redirected instruction leaves rd alone
  property p_redirect_no_write;
    @(posedge CLK) disable iff (!nRST) redirect |-> !rd_write;
  endproperty

  // The trapped pc lands in mepc and interrupts are masked
  property p_trap_saves_state;
    @(posedge CLK) disable iff (!nRST)
      trap_take |=> (mepc == $past(pc)) && !mstatus.mie;
  endproperty

  // Control outputs stay quiet during reset
  property p_quiet_in_reset;
    @(posedge CLK) !nRST |-> (!rd_write && !redirect && !timer_irq);
  endproperty

  a_redirect_no_write: assert property (p_redirect_no_write)
    else $error("rd_write high on a redirected instruction");

  a_trap_saves_state: assert property (p_trap_saves_state)
    else $error("trap did not save pc in mepc or left MIE set");

  a_quiet_in_reset: assert property (p_quiet_in_reset)
    else $error("control output active while nRST is low");

endmodule

`default_nettype wire

// File: verif/priv_csr_testdata.txt
// Columns are instr pc rs1_data ext_irq instr_retired, then the expected
// rd_data rd_write redirect redirect_pc, then the check mask
// Mask bits 0 to 3 check rd_data, rd_write, redirect and redirect_pc
// Bit 4 saves rd_data as base, bit 5 wants growth of at least the elapsed cycles
// Bit 6 wants growth equal to the rd_data column, bit 7 waits for timer_irq first
// Bit 8 wants timer_irq low, bit 9 drives no valid instruction, bit 10 adds a gap
// Bit 31 ends the data
340110F3 00000100 12345678 0 0 00000000 1 0 00000104 0000000E
340120F3 00000104 0000F0F0 0 0 12345678 1 0 00000108 0000000F
340130F3 00000108 FF00000F 0 0 1234F6F8 1 0 0000010C 0000000F
340AD0F3 0000010C DEADBEEF 0 0 0034F6F0 1 0 00000110 0000000F
340020F3 00000110 DEADBEEF 0 0 00000015 1 0 00000114 0000000F
301020F3 00000114 00000000 0 0 40000100 1 0 00000118 0000000F
305110F3 00000118 00000803 0 0 00000000 1 0 0000011C 0000000F
F11110F3 0000011C 00000001 0 0 00000000 0 1 00000800 0000000E
342020F3 00000800 00000000 0 0 00000002 1 0 00000804 0000000F
343020F3 00000804 00000000 0 0 F11110F3 1 0 00000808 0000000F
7FF020F3 00000808 00000000 0 0 00000000 0 1 00000800 0000000E
343020F3 00000800 00000000 0 0 7FF020F3 1 0 00000804 0000000F
300460F3 00000804 00000000 0 0 00001800 1 0 00000808 0000000F
00000073 00000200 00000000 0 0 00000000 0 1 00000800 0000000E
300020F3 00000800 00000000 0 0 00001880 1 0 00000804 0000000F
341020F3 00000804 00000000 0 0 00000200 1 0 00000808 0000000F
30200073 00000808 00000000 0 0 00000000 0 1 00000200 0000000E
300020F3 00000200 00000000 0 0 00001888 1 0 00000204 0000000F
304110F3 00000204 00000800 0 0 00000000 1 0 00000208 0000000F
340020F3 00000208 00000000 1 0 00000000 0 1 00000800 0000000E
342020F3 00000800 00000000 0 0 8000000B 1 0 00000804 0000000F
B00020F3 00000804 00000000 0 0 00000000 1 0 00000808 0000041E
00000000 00000000 00000000 0 0 00000000 0 0 00000000 00000606
B00020F3 00000808 00000000 0 0 00000000 1 0 0000080C 0000002E
B02020F3 0000080C 00000000 0 0 00000000 1 0 00000810 0000001E
00000000 00000000 00000000 0 1 00000000 0 0 00000000 00000206
00000000 00000000 00000000 0 1 00000000 0 0 00000000 00000206
340020F3 00000810 00000000 0 1 00000015 1 0 00000814 0000000F
B02020F3 00000814 00000000 0 0 00000003 1 0 00000818 0000004E
7C1110F3 00000818 00000100 0 0 00000000 1 0 0000081C 0000000E
7C0110F3 0000081C 00000120 0 0 00000000 1 0 00000820 0000010F
7C0020F3 00000820 00000000 0 0 00000120 1 0 00000824 0000010F
7C0110F3 00000824 FFFFFFF0 0 0 00000120 1 0 00000828 0000008F
7C0020F3 00000828 00000000 0 0 FFFFFFF0 1 0 0000082C 0000010F
00000000 00000000 00000000 0 0 00000000 0 0 00000000 80000000

// File: verif/tb_priv_csr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_priv_csr;

  localparam int NCOL          = 10;
  localparam int MAX_LINES     = 64;
  localparam int TIMER_TIMEOUT = 200;

  // Bits of the mask column
  localparam int M_RD    = 0;
  localparam int M_WR    = 1;
  localparam int M_RDIR  = 2;
  localparam int M_RPC   = 3;
  localparam int M_SAVE  = 4;
  localparam int M_GROWS = 5;
  localparam int M_DELTA = 6;
  localparam int M_TWAIT = 7;
  localparam int M_TLOW  = 8;
  localparam int M_IDLE  = 9;
  localparam int M_GAP   = 10;
  localparam int M_END   = 31;

  logic        CLK;
  logic        nRST;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] rs1_data;
  logic        instr_retired;
  logic        ext_irq;
  logic [31:0] rd_data;
  logic        rd_write;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        timer_irq;

  logic [31:0] vec [0:NCOL*MAX_LINES-1];
  logic [31:0] edge_count = '0;
  logic [31:0] base_edges;
  logic [31:0] base_value;
  integer      seed;
  int          errors;

  priv_csr_top u_dut (
    .CLK           (CLK),
    .nRST          (nRST),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .pc            (pc),
    .rs1_data      (rs1_data),
    .instr_retired (instr_retired),
    .ext_irq       (ext_irq),
    .rd_data       (rd_data),
    .rd_write      (rd_write),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .timer_irq     (timer_irq)
  );

  bind priv_csr_top priv_csr_assertions u_assertions (
    .CLK       (CLK),
    .nRST      (nRST),
    .rd_write  (rd_write),
    .redirect  (redirect),
    .timer_irq (timer_irq),
    .trap_take (trap_take),
    .pc        (pc),
    .mepc      (mepc),
    .mstatus   (mstatus)
  );

  always begin
    CLK = 1'b0;
    #10;
    CLK = 1'b1;
    #10;
  end

  // Free-running edge count that mcycle should keep pace with
  always @(posedge CLK) begin
    edge_count <= edge_count + 32'd1;
  end

  task automatic end_in_failure();
    errors++;
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    end_in_failure();
  endtask

  // The edge commits whatever was driven before it
  task automatic drive_idle();
    @(posedge CLK);
    instr_valid   <= 1'b0;
    instr_retired <= 1'b0;
    ext_irq       <= 1'b0;
  endtask

  task automatic drive_line(input int b);
    @(posedge CLK);
    instr_valid   <= !vec[b+9][M_IDLE];
    instr         <= vec[b];
    pc            <= vec[b+1];
    rs1_data      <= vec[b+2];
    ext_irq       <= vec[b+3][0];
    instr_retired <= vec[b+4][0];
  endtask

  task automatic wait_timer_irq();
    int n;
    n = 0;
    while (timer_irq !== 1'b1) begin
      if (n == TIMER_TIMEOUT) begin
        $display("timer_irq did not rise within %0d cycles", TIMER_TIMEOUT);
        end_in_failure();
      end
      drive_idle();
      @(negedge CLK);
      n++;
    end
  endtask

  task automatic check_line(input int ln, input int b);
    logic [31:0] mask;
    logic [31:0] exp_rd;
    logic        exp_wr;
    logic        exp_rdir;
    logic [31:0] exp_pc;
    mask     = vec[b+9];
    exp_rd   = vec[b+5];
    exp_wr   = vec[b+6][0];
    exp_rdir = vec[b+7][0];
    exp_pc   = vec[b+8];
    @(negedge CLK);
    if (mask[M_RD]) begin
      assert (rd_data === exp_rd)
        else report_mismatch($sformatf("vector %0d rd_data %h, expected %h",
                                       ln, rd_data, exp_rd));
    end
    if (mask[M_WR]) begin
      assert (rd_write === exp_wr)
        else report_mismatch($sformatf("vector %0d rd_write %b, expected %b",
                                       ln, rd_write, exp_wr));
    end
    if (mask[M_RDIR]) begin
      assert (redirect === exp_rdir)
        else report_mismatch($sformatf("vector %0d redirect %b, expected %b",
                                       ln, redirect, exp_rdir));
    end
    if (mask[M_RPC]) begin
      assert (redirect_pc === exp_pc)
        else report_mismatch($sformatf("vector %0d redirect_pc %h, expected %h",
                                       ln, redirect_pc, exp_pc));
    end
    if (mask[M_GROWS]) begin
      assert ((rd_data - base_value) >= (edge_count - base_edges))
        else report_mismatch($sformatf("vector %0d counter grew %0d in %0d cycles",
                                       ln, rd_data - base_value, edge_count - base_edges));
    end
    if (mask[M_DELTA]) begin
      assert ((rd_data - base_value) == exp_rd)
        else report_mismatch($sformatf("vector %0d counter grew %0d, expected %0d",
                                       ln, rd_data - base_value, exp_rd));
    end
    if (mask[M_TLOW]) begin
      assert (timer_irq === 1'b0)
        else report_mismatch($sformatf("vector %0d timer_irq high, expected low", ln));
    end
    if (mask[M_SAVE]) begin
      base_value = rd_data;
      base_edges = edge_count;
    end
  endtask

  initial begin
    int          ln;
    int          b;
    logic [31:0] mask;
    logic [31:0] rnd;
    logic        done;
    seed          = 32'hd649;
    errors        = 0;
    base_edges    = '0;
    base_value    = '0;
    nRST          <= 1'b0;
    instr_valid   <= 1'b0;
    instr         <= '0;
    pc            <= '0;
    rs1_data      <= '0;
    instr_retired <= 1'b0;
    ext_irq       <= 1'b0;
    $readmemh("verif/priv_csr_testdata.txt", vec);
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    ln   = 0;
    done = 1'b0;
    while (!done) begin
      if (ln == MAX_LINES) begin
        $display("data file ran past %0d vectors without an end marker", MAX_LINES);
        end_in_failure();
      end
      b    = ln * NCOL;
      mask = vec[b+9];
      if (mask[M_END]) begin
        done = 1'b1;
      end else begin
        if (mask[M_TWAIT]) begin
          wait_timer_irq();
        end
        drive_line(b);
        check_line(ln, b);
        // Idle cycles of random length between instructions
        if (mask[M_GAP]) begin
          rnd = $random(seed);
          repeat (int'(rnd[2:0]) + 1) drive_idle();
          @(negedge CLK);
        end
        ln++;
      end
    end
    drive_idle();
    @(negedge CLK);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      end_in_failure();
    end
  end

endmodule

`default_nettype wire
